// ==== logic/axi_slv_pkg.sv ====
package axi_slv_pkg;

	// bus widths.
	localparam int AXI_ADDR_W = 32;
	localparam int AXI_DATA_W = 64;
	localparam int AXI_STRB_W = AXI_DATA_W / 8;
	localparam int AXI_LEN_W = 8;

	// burst types as coded on AxBURST.
	typedef enum logic [1:0] {
		FIXED = 2'b00,
		INCR  = 2'b01,
		WRAP  = 2'b10
	} burst_e;

	// only OKAY is ever produced.
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} resp_e;

	typedef logic [AXI_DATA_W-1:0] axi_data_t;

endpackage

// ==== logic/axi_burst_addr.sv ====
module axi_burst_addr import axi_slv_pkg::*; #(
	parameter int MEM_AW = 14
) (
	input  logic                  CLK,
	input  logic                  rst,
	input  logic                  load,
	input  logic                  step,
	input  logic [AXI_ADDR_W-1:0] start_addr,
	input  logic [AXI_LEN_W-1:0]  len,
	input  burst_e                burst,
	output logic [MEM_AW-1:0]     addr,
	output logic                  last
);

	// byte offset bits below the word address.
	localparam int OFS_W = $clog2(AXI_STRB_W);

	logic [AXI_LEN_W-1:0] cnt;
	logic [AXI_LEN_W-1:0] len_q;
	burst_e               burst_q;
	logic [MEM_AW-1:0]    wrap_mask;
	logic [MEM_AW-1:0]    addr_inc;

	// window of len+1 words, a power of two for WRAP.
	assign wrap_mask = MEM_AW'(len_q);
	assign addr_inc = addr + 1'b1;
	assign last = (cnt == len_q);

	always_ff @(posedge CLK) begin
		if (rst) begin
			cnt <= '0;
			len_q <= '0;
			burst_q <= INCR;
		end else if (load) begin
			cnt <= '0;
			len_q <= len;
			burst_q <= burst;
		end else if (step) begin
			cnt <= cnt + 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (load) begin
			addr <= start_addr[OFS_W +: MEM_AW];
		end else if (step) begin
			case (burst_q)
				FIXED: addr <= addr;
				WRAP: addr <= (addr & ~wrap_mask) | (addr_inc & wrap_mask);
				default: addr <= addr_inc;
			endcase
		end
	end

endmodule

// ==== logic/slv_access_arb.sv ====
module slv_access_arb (
	input  logic CLK,
	input  logic rst,
	input  logic wr_req,
	input  logic rd_req,
	input  logic wr_done,
	input  logic rd_done,
	output logic wr_grant,
	output logic rd_grant
);

	logic busy;
	// set when the read side got the last grant.
	logic last_rd;

	// with both asking, the side not served last wins.
	assign wr_grant = ~busy & wr_req & (~rd_req | last_rd);
	assign rd_grant = ~busy & rd_req & (~wr_req | ~last_rd);

	always_ff @(posedge CLK) begin
		if (rst) begin
			busy <= 1'b0;
			last_rd <= 1'b1;
		end else if (wr_grant | rd_grant) begin
			busy <= 1'b1;
			last_rd <= rd_grant;
		end else if (wr_done | rd_done) begin
			busy <= 1'b0;
		end
	end

endmodule

// ==== logic/axi_wr_channel.sv ====
module axi_wr_channel import axi_slv_pkg::*; #(
	parameter int MEM_AW = 14
) (
	input  logic                  CLK,
	input  logic                  rst,
	input  logic [AXI_ADDR_W-1:0] awaddr,
	input  logic [AXI_LEN_W-1:0]  awlen,
	input  logic [2:0]            awsize,
	input  burst_e                awburst,
	input  logic                  awvalid,
	output logic                  awready,
	input  axi_data_t             wdata,
	input  logic [AXI_STRB_W-1:0] wstrb,
	input  logic                  wlast,
	input  logic                  wvalid,
	output logic                  wready,
	output resp_e                 bresp,
	output logic                  bvalid,
	input  logic                  bready,
	input  logic                  wr_grant,
	output logic                  wr_req,
	output logic                  wr_done,
	output logic                  wr_en,
	output logic [MEM_AW-1:0]     wr_addr,
	output axi_data_t             wr_data,
	output logic [AXI_STRB_W-1:0] wr_strb
);

	typedef enum logic [1:0] {
		WR_IDLE,
		WR_WAIT,
		WR_DATA,
		WR_RESP
	} wr_state_e;

	wr_state_e             state;
	logic                  load;
	logic                  beat;
	logic                  burst_last;
	logic [AXI_ADDR_W-1:0] start_addr;

	assign wr_req = awvalid & ((state == WR_IDLE) | (state == WR_WAIT));
	assign load = awready & awvalid;
	assign beat = wready & wvalid;

	// start address aligned to the transfer size.
	assign start_addr = awaddr & ~((AXI_ADDR_W'(1) << awsize) - AXI_ADDR_W'(1));

	// each accepted beat goes straight into the SRAM.
	assign wr_en = beat;
	assign wr_data = wdata;
	assign wr_strb = wstrb;

	assign bresp = OKAY;
	assign wr_done = bvalid & bready;

	axi_burst_addr #(
		.MEM_AW(MEM_AW)
	) i_wr_addr (
		.CLK(CLK),
		.rst(rst),
		.load(load),
		.step(beat),
		.start_addr(start_addr),
		.len(awlen),
		.burst(awburst),
		.addr(wr_addr),
		.last(burst_last)
	);

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= WR_IDLE;
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			awready <= 1'b0;
			case (state)
				WR_IDLE, WR_WAIT: begin
					if (wr_grant) begin
						awready <= 1'b1;
						state <= WR_DATA;
					end else if (awvalid) begin
						state <= WR_WAIT;
					end
				end
				WR_DATA: begin
					if (load) begin
						wready <= 1'b1;
					end
					// an early wlast also closes the burst.
					if (beat && (burst_last || wlast)) begin
						wready <= 1'b0;
						bvalid <= 1'b1;
						state <= WR_RESP;
					end
				end
				WR_RESP: begin
					if (bready) begin
						bvalid <= 1'b0;
						state <= WR_IDLE;
					end
				end
				default: state <= WR_IDLE;
			endcase
		end
	end

endmodule

// ==== logic/axi_rd_channel.sv ====
module axi_rd_channel import axi_slv_pkg::*; #(
	parameter int MEM_AW = 14
) (
	input  logic                  CLK,
	input  logic                  rst,
	input  logic [AXI_ADDR_W-1:0] araddr,
	input  logic [AXI_LEN_W-1:0]  arlen,
	input  logic [2:0]            arsize,
	input  burst_e                arburst,
	input  logic                  arvalid,
	output logic                  arready,
	output axi_data_t             rdata,
	output resp_e                 rresp,
	output logic                  rlast,
	output logic                  rvalid,
	input  logic                  rready,
	input  logic                  rd_grant,
	output logic                  rd_req,
	output logic                  rd_done,
	output logic                  rd_en,
	output logic [MEM_AW-1:0]     rd_addr,
	input  axi_data_t             rd_data
);

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_WAIT,
		RD_FETCH,
		RD_PRESENT
	} rd_state_e;

	rd_state_e             state;
	logic                  load;
	logic                  xfer;
	logic                  burst_last;
	logic [AXI_ADDR_W-1:0] start_addr;

	assign rd_req = arvalid & ((state == RD_IDLE) | (state == RD_WAIT));
	assign load = arready & arvalid;
	assign xfer = rvalid & rready;

	// start address aligned to the transfer size.
	assign start_addr = araddr & ~((AXI_ADDR_W'(1) << arsize) - AXI_ADDR_W'(1));

	// no fetch in the acceptance cycle, the address is still loading.
	assign rd_en = (state == RD_FETCH) & ~arready;

	// the SRAM holds its output until the next rd_en.
	assign rdata = rd_data;
	assign rresp = OKAY;
	assign rd_done = xfer & rlast;

	axi_burst_addr #(
		.MEM_AW(MEM_AW)
	) i_rd_addr (
		.CLK(CLK),
		.rst(rst),
		.load(load),
		.step(xfer),
		.start_addr(start_addr),
		.len(arlen),
		.burst(arburst),
		.addr(rd_addr),
		.last(burst_last)
	);

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= RD_IDLE;
			arready <= 1'b0;
			rvalid <= 1'b0;
			rlast <= 1'b0;
		end else begin
			arready <= 1'b0;
			case (state)
				RD_IDLE, RD_WAIT: begin
					if (rd_grant) begin
						arready <= 1'b1;
						state <= RD_FETCH;
					end else if (arvalid) begin
						state <= RD_WAIT;
					end
				end
				RD_FETCH: begin
					// data arrives with rvalid next cycle.
					if (rd_en) begin
						rvalid <= 1'b1;
						rlast <= burst_last;
						state <= RD_PRESENT;
					end
				end
				RD_PRESENT: begin
					if (rready) begin
						rvalid <= 1'b0;
						rlast <= 1'b0;
						state <= rlast ? RD_IDLE : RD_FETCH;
					end
				end
				default: state <= RD_IDLE;
			endcase
		end
	end

endmodule

// ==== logic/gen_sram.sv ====
module gen_sram import axi_slv_pkg::*; #(
	parameter int MEM_AW = 14
) (
	input  logic                  CLK,
	input  logic                  wr_en,
	input  logic [MEM_AW-1:0]     wr_addr,
	input  axi_data_t             wr_data,
	input  logic [AXI_STRB_W-1:0] wr_strb,
	input  logic                  rd_en,
	input  logic [MEM_AW-1:0]     rd_addr,
	output axi_data_t             rd_data
);

	localparam int DEPTH = 2 ** MEM_AW;

	axi_data_t mem [DEPTH];

	// word k starts out holding k.
	initial begin
		for (int k = 0; k < DEPTH; k++) begin
			mem[k] = AXI_DATA_W'(k);
		end
	end

	always @(posedge CLK) begin
		if (wr_en) begin
			for (int b = 0; b < AXI_STRB_W; b++) begin
				if (wr_strb[b]) begin
					mem[wr_addr][8*b +: 8] <= wr_data[8*b +: 8];
				end
			end
		end
	end

	// registered read, held while rd_en is low.
	always_ff @(posedge CLK) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

// ==== logic/axi_full_slv_sram.sv ====
module axi_full_slv_sram import axi_slv_pkg::*; #(
	parameter int MEM_AW = 14
) (
	input  logic                  CLK,
	input  logic                  rst,
	input  logic [AXI_ADDR_W-1:0] awaddr,
	input  logic [AXI_LEN_W-1:0]  awlen,
	input  logic [2:0]            awsize,
	input  burst_e                awburst,
	input  logic                  awvalid,
	output logic                  awready,
	input  axi_data_t             wdata,
	input  logic [AXI_STRB_W-1:0] wstrb,
	input  logic                  wlast,
	input  logic                  wvalid,
	output logic                  wready,
	output resp_e                 bresp,
	output logic                  bvalid,
	input  logic                  bready,
	input  logic [AXI_ADDR_W-1:0] araddr,
	input  logic [AXI_LEN_W-1:0]  arlen,
	input  logic [2:0]            arsize,
	input  burst_e                arburst,
	input  logic                  arvalid,
	output logic                  arready,
	output axi_data_t             rdata,
	output resp_e                 rresp,
	output logic                  rlast,
	output logic                  rvalid,
	input  logic                  rready
);

	logic                  wr_req;
	logic                  rd_req;
	logic                  wr_grant;
	logic                  rd_grant;
	logic                  wr_done;
	logic                  rd_done;
	logic                  wr_en;
	logic [MEM_AW-1:0]     wr_addr;
	axi_data_t             wr_data;
	logic [AXI_STRB_W-1:0] wr_strb;
	logic                  rd_en;
	logic [MEM_AW-1:0]     rd_addr;
	axi_data_t             rd_data;

	axi_wr_channel #(
		.MEM_AW(MEM_AW)
	) i_wr_channel (
		.CLK(CLK),
		.rst(rst),
		.awaddr(awaddr),
		.awlen(awlen),
		.awsize(awsize),
		.awburst(awburst),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wlast(wlast),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.wr_grant(wr_grant),
		.wr_req(wr_req),
		.wr_done(wr_done),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.wr_strb(wr_strb)
	);

	axi_rd_channel #(
		.MEM_AW(MEM_AW)
	) i_rd_channel (
		.CLK(CLK),
		.rst(rst),
		.araddr(araddr),
		.arlen(arlen),
		.arsize(arsize),
		.arburst(arburst),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rlast(rlast),
		.rvalid(rvalid),
		.rready(rready),
		.rd_grant(rd_grant),
		.rd_req(rd_req),
		.rd_done(rd_done),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

	slv_access_arb i_arb (
		.CLK(CLK),
		.rst(rst),
		.wr_req(wr_req),
		.rd_req(rd_req),
		.wr_done(wr_done),
		.rd_done(rd_done),
		.wr_grant(wr_grant),
		.rd_grant(rd_grant)
	);

	gen_sram #(
		.MEM_AW(MEM_AW)
	) i_sram (
		.CLK(CLK),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.wr_strb(wr_strb),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

endmodule

// ==== testbench/axi_full_slv_sram_chk.sv ====
module axi_full_slv_sram_chk import axi_slv_pkg::*; (
	input logic      CLK,
	input logic      rst,
	input logic      awready,
	input logic      wready,
	input logic      bvalid,
	input logic      bready,
	input logic      arready,
	input logic      rvalid,
	input logic      rready,
	input logic      rlast,
	input axi_data_t rdata
);

	timeunit 1ns;
	timeprecision 1ps;

	// write response waits for the master.
	bvalid_hold: assert property (@(posedge CLK) disable iff (rst)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

	// read beat frozen under back-pressure.
	r_stable: assert property (@(posedge CLK) disable iff (rst)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rlast))
		else $error("read beat changed while rready was low");

	// only one burst owns the SRAM.
	one_burst: assert property (@(posedge CLK) disable iff (rst)
		!(wready && rvalid))
		else $error("write data and read data active together");

	reset_idle: assert property (@(posedge CLK)
		rst |=> !awready && !wready && !bvalid && !arready && !rvalid && !rlast)
		else $error("handshake outputs not low after reset");

endmodule

bind axi_full_slv_sram axi_full_slv_sram_chk i_chk (
	.CLK(CLK),
	.rst(rst),
	.awready(awready),
	.wready(wready),
	.bvalid(bvalid),
	.bready(bready),
	.arready(arready),
	.rvalid(rvalid),
	.rready(rready),
	.rlast(rlast),
	.rdata(rdata)
);

// ==== testbench/axi_full_slv_sram_tb.sv ====
module axi_full_slv_sram_tb import axi_slv_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int MEM_AW = 14;
	localparam string TRACE_FILE = "testbench/axi_trace.txt";

	logic                  CLK;
	logic                  rst;
	logic [AXI_ADDR_W-1:0] awaddr;
	logic [AXI_LEN_W-1:0]  awlen;
	logic [2:0]            awsize;
	burst_e                awburst;
	logic                  awvalid;
	logic                  awready;
	axi_data_t             wdata;
	logic [AXI_STRB_W-1:0] wstrb;
	logic                  wlast;
	logic                  wvalid;
	logic                  wready;
	resp_e                 bresp;
	logic                  bvalid;
	logic                  bready;
	logic [AXI_ADDR_W-1:0] araddr;
	logic [AXI_LEN_W-1:0]  arlen;
	logic [2:0]            arsize;
	burst_e                arburst;
	logic                  arvalid;
	logic                  arready;
	axi_data_t             rdata;
	resp_e                 rresp;
	logic                  rlast;
	logic                  rvalid;
	logic                  rready;

	// one entry per trace operation.
	logic [7:0]            op_kind[$];
	logic [AXI_ADDR_W-1:0] op_addr[$];
	logic [AXI_LEN_W-1:0]  op_len[$];
	burst_e                op_burst[$];
	int                    op_base[$];
	// beats of all operations, in trace order.
	axi_data_t             beat_data[$];
	logic [AXI_STRB_W-1:0] beat_strb[$];

	int cycles = 0;
	int limit = 0;

	axi_full_slv_sram #(
		.MEM_AW(MEM_AW)
	) i_dut (.*);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("timeout: the trace did not complete within %0d cycles", limit);
			stop_failed();
		end
	end

	task automatic stop_failed();
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_data(input axi_data_t got, input axi_data_t exp, input string name);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s: got %h expected %h", $time, name, got, exp);
			stop_failed();
		end
	endtask

	task automatic check_resp(input resp_e got, input resp_e exp, input string name);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s: got %s expected %s", $time, name, got.name(), exp.name());
			stop_failed();
		end
	endtask

	task automatic check_last(input logic got, input logic exp, input string name);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s: got %b expected %b", $time, name, got, exp);
			stop_failed();
		end
	endtask

	task automatic load_trace();
		int                    fd;
		int                    rc;
		int                    n;
		int                    want;
		int                    burst_raw;
		logic [7:0]            op;
		logic [AXI_ADDR_W-1:0] addr;
		logic [AXI_LEN_W-1:0]  len;
		axi_data_t             data;
		logic [AXI_STRB_W-1:0] strb;
		logic [8*256-1:0]      skip;
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			$display("cannot open the trace file %s", TRACE_FILE);
			stop_failed();
		end
		rc = $fscanf(fd, " %c", op);
		while (rc == 1) begin
			if (op == "#") begin
				rc = $fgets(skip, fd);
			end else begin
				rc = $fscanf(fd, "%h %h %h", addr, len, burst_raw);
				if (rc != 3 || !(op == "W" || op == "R" || op == "P")) begin
					$display("malformed trace entry after operation %0d", op_kind.size());
					stop_failed();
				end
				op_kind.push_back(op);
				op_addr.push_back(addr);
				op_len.push_back(len);
				op_burst.push_back(burst_e'(burst_raw[1:0]));
				op_base.push_back(beat_data.size());
				// read beats carry only the expected data.
				want = (op == "R") ? 1 : 2;
				for (n = 0; n <= int'(len); n++) begin
					strb = '0;
					if (op == "R") begin
						rc = $fscanf(fd, "%h", data);
					end else begin
						rc = $fscanf(fd, "%h %h", data, strb);
					end
					if (rc != want) begin
						$display("trace ends inside the beats of operation %0d", op_kind.size());
						stop_failed();
					end
					beat_data.push_back(data);
					beat_strb.push_back(strb);
				end
			end
			rc = $fscanf(fd, " %c", op);
		end
		$fclose(fd);
	endtask

	task automatic drive_write(input int idx);
		int   base;
		int   b;
		logic hs;
		base = op_base[idx];
		awaddr = op_addr[idx];
		awlen = op_len[idx];
		awsize = 3'd3;
		awburst = op_burst[idx];
		awvalid = 1'b1;
		hs = 1'b0;
		while (!hs) begin
			@(negedge CLK);
			hs = awready;
			@(posedge CLK);
			#2;
		end
		awvalid = 1'b0;
		for (b = 0; b <= int'(op_len[idx]); b++) begin
			wdata = beat_data[base + b];
			wstrb = beat_strb[base + b];
			wlast = (b == int'(op_len[idx]));
			wvalid = 1'b1;
			hs = 1'b0;
			while (!hs) begin
				@(negedge CLK);
				hs = wready;
				@(posedge CLK);
				#2;
			end
		end
		wvalid = 1'b0;
		wlast = 1'b0;
		// response taken under random back-pressure.
		hs = 1'b0;
		while (!hs) begin
			bready = ($urandom % 4) != 0;
			@(negedge CLK);
			hs = bvalid & bready;
			if (hs) begin
				check_resp(bresp, OKAY, "bresp");
			end
			@(posedge CLK);
			#2;
		end
		bready = 1'b0;
	endtask

	task automatic drive_read(input int idx);
		int   base;
		int   b;
		logic hs;
		base = op_base[idx];
		araddr = op_addr[idx];
		arlen = op_len[idx];
		arsize = 3'd3;
		arburst = op_burst[idx];
		arvalid = 1'b1;
		hs = 1'b0;
		while (!hs) begin
			@(negedge CLK);
			hs = arready;
			@(posedge CLK);
			#2;
		end
		arvalid = 1'b0;
		b = 0;
		while (b <= int'(op_len[idx])) begin
			rready = ($urandom % 4) != 0;
			@(negedge CLK);
			if (rvalid && rready) begin
				check_data(rdata, beat_data[base + b], "rdata");
				check_last(rlast, b == int'(op_len[idx]), "rlast");
				check_resp(rresp, OKAY, "rresp");
				b++;
			end
			@(posedge CLK);
			#2;
		end
		rready = 1'b0;
	endtask

	initial begin
		int i;
		void'($urandom(28));
		rst = 1'b1;
		awaddr = '0;
		awlen = '0;
		awsize = 3'd3;
		awburst = INCR;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wlast = 1'b0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arlen = '0;
		arsize = 3'd3;
		arburst = INCR;
		arvalid = 1'b0;
		rready = 1'b0;
		load_trace();
		limit = 200 + 20 * beat_data.size();
		repeat (16) @(posedge CLK);
		#2;
		rst = 1'b0;
		i = 0;
		while (i < op_kind.size()) begin
			if (op_kind[i] == "P") begin
				if (i + 1 >= op_kind.size() || op_kind[i + 1] != "R") begin
					$display("trace pairs a write at operation %0d with no read", i);
					stop_failed();
				end
				// both address valids rise in the same cycle.
				fork
					drive_write(i);
					drive_read(i + 1);
				join
				i += 2;
			end else if (op_kind[i] == "W") begin
				drive_write(i);
				i++;
			end else begin
				drive_read(i);
				i++;
			end
		end
		repeat (4) @(posedge CLK);
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// ==== testbench/axi_trace.txt ====
# columns: op addr len burst, then len+1 beats (burst 0 FIXED, 1 INCR, 2 WRAP)
# W and P beats are data and strobe, R beats are expected data; P goes out with the next R
# untouched words hold their own index
R 00000100 03 1
0000000000000020 0000000000000021 0000000000000022 0000000000000023
# INCR write and read back
W 00000200 03 1
1111111111111111 ff 2222222222222222 ff 3333333333333333 ff 4444444444444444 ff
R 00000200 03 1
1111111111111111 2222222222222222 3333333333333333 4444444444444444
# partial strobes
W 00000208 01 1
aaaaaaaaaaaaaaaa 0f bbbbbbbbbbbbbbbb f0
R 00000200 03 1
1111111111111111 22222222aaaaaaaa bbbbbbbb33333333 4444444444444444
# FIXED write keeps only the last beat
W 00000300 02 0
5555555555555555 ff 6666666666666666 ff 7777777777777777 ff
R 000002f8 02 1
000000000000005f 7777777777777777 0000000000000061
# WRAP bursts starting mid-window
R 00000110 03 2
0000000000000022 0000000000000023 0000000000000020 0000000000000021
W 00000418 03 2
a0a0a0a0a0a0a0a0 ff a1a1a1a1a1a1a1a1 ff a2a2a2a2a2a2a2a2 ff a3a3a3a3a3a3a3a3 ff
R 00000400 03 1
a1a1a1a1a1a1a1a1 a2a2a2a2a2a2a2a2 a3a3a3a3a3a3a3a3 a0a0a0a0a0a0a0a0
R 00000208 01 2
22222222aaaaaaaa 1111111111111111
# eight beat INCR read
R 00001000 07 1
0000000000000200 0000000000000201 0000000000000202 0000000000000203
0000000000000204 0000000000000205 0000000000000206 0000000000000207
# last grant was a read so the write goes first
P 00000800 01 1
c0c0c0c0c0c0c0c0 ff c1c1c1c1c1c1c1c1 ff
R 00000800 01 1
c0c0c0c0c0c0c0c0 c1c1c1c1c1c1c1c1
W 00000900 00 1
d0d0d0d0d0d0d0d0 ff
# last grant was a write so the read goes first
P 00000900 00 1
e0e0e0e0e0e0e0e0 3c
R 00000900 00 1
d0d0d0d0d0d0d0d0
R 00000900 00 1
d0d0e0e0e0e0d0d0
# write first again
P 00000808 00 1
f0f0f0f0f0f0f0f0 ff
R 00000800 01 1
c0c0c0c0c0c0c0c0 f0f0f0f0f0f0f0f0

// ==== compile.f ====
logic/axi_slv_pkg.sv
logic/axi_burst_addr.sv
logic/slv_access_arb.sv
logic/axi_wr_channel.sv
logic/axi_rd_channel.sv
logic/gen_sram.sv
logic/axi_full_slv_sram.sv
testbench/axi_full_slv_sram_chk.sv
testbench/axi_full_slv_sram_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the AXI SRAM slave testbench with Verilator, run it and check the log.
cd "$(dirname "$0")" || exit 1

top=axi_full_slv_sram_tb
log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module "$top" -f compile.f -o "$top"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/"$top" > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "^SIMULATION PASSED$" "$log"; then
	echo "result: pass"
	exit 0
fi
echo "result: fail"
exit 1
